// ==== rtl/uart_pkg.sv ====
// line-level constants for the UART engines and the config register block
// import inside a module body; use scoped names in port lists

package uart_pkg;

	// fixed 8N1 character
	localparam int data_bits = 8;

	// bit period register width, in clock cycles
	localparam int div_w = 16;

	// 50 MHz clock at 115200 baud
	localparam logic [div_w-1:0] reset_div = 16'd434;

	// idle cycles in mid-frame before the receiver gives up, about 1 ms
	localparam logic [div_w-1:0] reset_timeout = 16'd50000;

	// register select on the host config port
	typedef enum logic {
		cfg_div     = 1'b0,
		cfg_timeout = 1'b1
	} cfg_addr_e;

endpackage

// ==== rtl/frame_pkg.sv ====
// string buffer sizes, brace characters and framer state encodings
// shared by frame_tx, frame_rx and the top level

package frame_pkg;

	// payload limits, byte 0 sits in the lowest 8 bits of a buffer
	localparam int max_bytes = 32;
	localparam int len_w     = 6;
	localparam int str_w     = 256;

	// frame delimiters
	localparam logic [7:0] open_ch  = 8'h7b;
	localparam logic [7:0] close_ch = 8'h7d;

	// transmit framer, one state per character being sent
	typedef enum logic [2:0] {
		ftx_idle, ftx_open1, ftx_open2, ftx_body, ftx_close1, ftx_close2, ftx_done
	} ftx_state_e;

	// receive framer
	typedef enum logic [2:0] {
		frx_hunt, frx_open2, frx_body, frx_close2_wait, frx_done
	} frx_state_e;

endpackage

// ==== rtl/uart_cfg_regs.sv ====
`timescale 1ns/100ps
// host-writable bit period and idle timeout for the UART engines
// single-cycle cfg_wr with cfg_addr and cfg_data valid on the same edge

module uart_cfg_regs (
	input  logic                       sys_clk,
	input  logic                       sys_rst_n,
	input  logic                       cfg_wr,
	input  uart_pkg::cfg_addr_e        cfg_addr,
	input  logic [uart_pkg::div_w-1:0] cfg_data,
	output logic [uart_pkg::div_w-1:0] bit_div,
	output logic [uart_pkg::div_w-1:0] rx_timeout
);
	import uart_pkg::*;

	logic [div_w-1:0] div_clamped;

	// below 4 the receiver half-period wait collapses
	assign div_clamped = (cfg_data < div_w'(4)) ? div_w'(4) : cfg_data;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_div    <= reset_div;
			rx_timeout <= reset_timeout;
		end else if (cfg_wr) begin
			case (cfg_addr)
				cfg_div:     bit_div    <= div_clamped;
				cfg_timeout: rx_timeout <= cfg_data;
				default:     bit_div    <= bit_div;
			endcase
		end
	end

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/100ps
// 8N1 serializer, one character per send_strobe
// start bit goes out one cycle after the strobe, sent marks the last stop-bit cycle
// strobes while a character is on the line are dropped

module uart_tx (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [uart_pkg::div_w-1:0]     bit_div,
	input  logic                           send_strobe,
	input  logic [uart_pkg::data_bits-1:0] send_byte,
	output logic                           txd,
	output logic                           sent
);
	import uart_pkg::*;

	logic                 busy;
	logic [div_w-1:0]     div_q;
	logic [div_w-1:0]     bit_cnt;
	// 0 is the start bit, data_bits + 1 the stop bit
	logic [3:0]           bit_idx;
	logic [data_bits-1:0] data_q;
	logic                 bit_end;

	assign bit_end = busy && (bit_cnt == div_q - 1'b1);
	assign sent    = bit_end && (bit_idx == 4'(data_bits + 1));

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy    <= 1'b0;
			txd     <= 1'b1;
			div_q   <= reset_div;
			bit_cnt <= '0;
			bit_idx <= '0;
		end else if (!busy) begin
			if (send_strobe) begin
				busy    <= 1'b1;
				txd     <= 1'b0;
				// period frozen for the whole character
				div_q   <= bit_div;
				bit_cnt <= '0;
				bit_idx <= '0;
			end
		end else if (bit_end) begin
			bit_cnt <= '0;
			if (sent) begin
				busy <= 1'b0;
			end else begin
				bit_idx <= bit_idx + 1'b1;
				// lsb first, then the stop bit
				txd     <= (bit_idx < 4'(data_bits)) ? data_q[bit_idx[2:0]] : 1'b1;
			end
		end else begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!busy && send_strobe)
			data_q <= send_byte;
	end

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/100ps
// 8N1 deserializer with mid-bit sampling
// byte_vld pulses at mid stop bit when the stop bit is high
// line_idle_to fires once after rx_timeout idle cycles following a byte

module uart_rx (
	input  logic                           sys_clk,
	input  logic                           sys_rst_n,
	input  logic [uart_pkg::div_w-1:0]     bit_div,
	input  logic [uart_pkg::div_w-1:0]     rx_timeout,
	input  logic                           rxd,
	output logic                           byte_vld,
	output logic [uart_pkg::data_bits-1:0] byte_data,
	output logic                           line_idle_to
);
	import uart_pkg::*;

	logic                 rxd_s1;
	logic                 rxd_s2;
	logic                 rxd_d;
	logic                 active;
	logic [div_w-1:0]     div_q;
	logic [div_w-1:0]     cnt;
	logic [3:0]           bit_idx;
	logic [data_bits-1:0] shreg;
	logic                 sample;
	logic                 idle_armed;
	logic [div_w-1:0]     idle_cnt;

	assign sample    = active && (cnt == div_w'(1));
	assign byte_vld  = sample && (bit_idx == 4'(data_bits + 1)) && rxd_s2;
	assign byte_data = shreg;

	// two-flop synchronizer plus one delay for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rxd_s1 <= 1'b1;
			rxd_s2 <= 1'b1;
			rxd_d  <= 1'b1;
		end else begin
			rxd_s1 <= rxd;
			rxd_s2 <= rxd_s1;
			rxd_d  <= rxd_s2;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active  <= 1'b0;
			div_q   <= reset_div;
			cnt     <= '0;
			bit_idx <= '0;
		end else if (!active) begin
			if (rxd_d && !rxd_s2) begin
				// falling edge, wait half a bit to reach the start bit centre
				active  <= 1'b1;
				div_q   <= bit_div;
				cnt     <= {1'b0, bit_div[div_w-1:1]};
				bit_idx <= '0;
			end
		end else if (sample) begin
			cnt <= div_q;
			if (bit_idx == '0 && rxd_s2)
				active <= 1'b0;
			else if (bit_idx == 4'(data_bits + 1))
				active <= 1'b0;
			else
				bit_idx <= bit_idx + 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
		end
	end

	// data bits arrive lsb first
	always_ff @(posedge sys_clk) begin
		if (sample && bit_idx != '0 && bit_idx <= 4'(data_bits))
			shreg <= {rxd_s2, shreg[data_bits-1:1]};
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			idle_armed   <= 1'b0;
			idle_cnt     <= '0;
			line_idle_to <= 1'b0;
		end else begin
			line_idle_to <= 1'b0;
			if (active) begin
				idle_cnt <= '0;
			end else if (idle_armed) begin
				if (idle_cnt >= rx_timeout) begin
					idle_armed   <= 1'b0;
					line_idle_to <= 1'b1;
				end else begin
					idle_cnt <= idle_cnt + 1'b1;
				end
			end
			if (byte_vld)
				idle_armed <= 1'b1;
		end
	end

endmodule

// ==== rtl/frame_tx.sv ====
`timescale 1ns/100ps
// wraps a payload of 1 to 32 bytes as {{payload}} and feeds uart_tx
// tx_req is taken only while tx_busy is low, the payload is latched on accept
// tx_done pulses one cycle after the last sent, as tx_busy drops

module frame_tx (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic                         tx_req,
	input  logic [frame_pkg::str_w-1:0]  tx_string,
	input  logic [frame_pkg::len_w-1:0]  tx_length,
	output logic                         send_strobe,
	output logic [7:0]                   send_byte,
	input  logic                         sent,
	output logic                         tx_busy,
	output logic                         tx_done
);
	import frame_pkg::*;

	ftx_state_e       state;
	logic [str_w-1:0] str_q;
	logic [len_w-1:0] len_q;
	// payload bytes handed to the serializer so far
	logic [len_w-1:0] cnt;
	logic             accept;

	assign tx_busy = (state != ftx_idle) && (state != ftx_done);
	assign tx_done = (state == ftx_done);
	assign accept  = tx_req && !tx_busy && (tx_length != '0)
		&& (tx_length <= len_w'(max_bytes));

	// next character is strobed the cycle after sent
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state       <= ftx_idle;
			send_strobe <= 1'b0;
			cnt         <= '0;
		end else begin
			send_strobe <= 1'b0;
			case (state)
				ftx_idle, ftx_done: begin
					state <= ftx_idle;
					if (accept) begin
						state       <= ftx_open1;
						send_strobe <= 1'b1;
					end
				end
				ftx_open1: if (sent) begin
					state       <= ftx_open2;
					send_strobe <= 1'b1;
				end
				ftx_open2: if (sent) begin
					state       <= ftx_body;
					send_strobe <= 1'b1;
					cnt         <= len_w'(1);
				end
				ftx_body: if (sent) begin
					send_strobe <= 1'b1;
					if (cnt == len_q)
						state <= ftx_close1;
					else
						cnt <= cnt + 1'b1;
				end
				ftx_close1: if (sent) begin
					state       <= ftx_close2;
					send_strobe <= 1'b1;
				end
				ftx_close2: if (sent)
					state <= ftx_done;
				default: state <= ftx_idle;
			endcase
		end
	end

	// payload shifts down one byte per body character
	always_ff @(posedge sys_clk) begin
		if (accept) begin
			str_q     <= tx_string;
			len_q     <= tx_length;
			send_byte <= open_ch;
		end else if (sent) begin
			if (state == ftx_open1) begin
				send_byte <= open_ch;
			end else if (state == ftx_open2 || (state == ftx_body && cnt != len_q)) begin
				send_byte <= str_q[7:0];
				str_q     <= {8'h00, str_q[str_w-1:8]};
			end else if (state == ftx_body || state == ftx_close1) begin
				send_byte <= close_ch;
			end
		end
	end

endmodule

// ==== rtl/frame_rx.sv ====
`timescale 1ns/100ps
// hunts for {{ and collects payload bytes until }} arrives
// a lone } followed by another byte stays in the payload
// idle timeout or more than 32 bytes drops the frame silently
// rx_string and rx_length hold until the next good frame

module frame_rx (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic                         byte_vld,
	input  logic [7:0]                   byte_data,
	input  logic                         line_idle_to,
	output logic [frame_pkg::str_w-1:0]  rx_string,
	output logic [frame_pkg::len_w-1:0]  rx_length,
	output logic                         rx_busy,
	output logic                         rx_done
);
	import frame_pkg::*;

	frx_state_e       state;
	logic [str_w-1:0] work;
	logic [len_w-1:0] cnt;
	logic [len_w-1:0] cnt_nxt;
	logic             is_open;
	logic             is_close;
	logic             abort_to;
	logic             store_one;
	logic             store_two;
	logic             overflow;
	logic             finish;

	assign rx_busy  = (state != frx_hunt);
	assign rx_done  = (state == frx_done);
	assign cnt_nxt  = cnt + 1'b1;
	assign is_open  = byte_vld && (byte_data == open_ch);
	assign is_close = byte_vld && (byte_data == close_ch);
	assign abort_to = line_idle_to && (state != frx_hunt);

	// ordinary byte in body, or pending } plus the byte after it
	assign store_one = (state == frx_body) && byte_vld && !is_close && !abort_to;
	assign store_two = (state == frx_close2_wait) && byte_vld && !is_close && !abort_to;
	assign overflow  = (store_one && cnt == len_w'(max_bytes))
		|| (store_two && cnt > len_w'(max_bytes - 2));
	assign finish    = (state == frx_close2_wait) && is_close && !abort_to;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state     <= frx_hunt;
			cnt       <= '0;
			rx_length <= '0;
		end else if (abort_to || overflow) begin
			state <= frx_hunt;
		end else begin
			case (state)
				frx_hunt: if (is_open)
					state <= frx_open2;
				frx_open2: begin
					if (is_open) begin
						state <= frx_body;
						cnt   <= '0;
					end else if (byte_vld) begin
						state <= frx_hunt;
					end
				end
				frx_body: begin
					if (is_close)
						state <= frx_close2_wait;
					else if (store_one)
						cnt <= cnt_nxt;
				end
				frx_close2_wait: begin
					if (finish) begin
						state     <= frx_done;
						rx_length <= cnt;
					end else if (store_two) begin
						state <= frx_body;
						cnt   <= cnt + len_w'(2);
					end
				end
				default: state <= frx_hunt;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == frx_open2 && is_open && !abort_to) begin
			work <= '0;
		end else if (store_one && !overflow) begin
			work[{cnt[4:0], 3'b000} +: 8] <= byte_data;
		end else if (store_two && !overflow) begin
			work[{cnt[4:0], 3'b000} +: 8]     <= close_ch;
			work[{cnt_nxt[4:0], 3'b000} +: 8] <= byte_data;
		end
		if (finish)
			rx_string <= work;
	end

endmodule

// ==== rtl/uart_string_link.sv ====
`timescale 1ns/100ps
// framed string link over one UART, {{payload}} in both directions
// host writes bit period and idle timeout through cfg_wr, cfg_addr, cfg_data
// tx_req sends a frame, rx_done reports a received one

module uart_string_link (
	input  logic                         sys_clk,
	input  logic                         sys_rst_n,
	input  logic                         cfg_wr,
	input  uart_pkg::cfg_addr_e          cfg_addr,
	input  logic [uart_pkg::div_w-1:0]   cfg_data,
	input  logic                         tx_req,
	input  logic [frame_pkg::str_w-1:0]  tx_string,
	input  logic [frame_pkg::len_w-1:0]  tx_length,
	output logic                         tx_busy,
	output logic                         tx_done,
	output logic [frame_pkg::str_w-1:0]  rx_string,
	output logic [frame_pkg::len_w-1:0]  rx_length,
	output logic                         rx_busy,
	output logic                         rx_done,
	input  logic                         uart_rxd,
	output logic                         uart_txd
);
	import uart_pkg::*;

	logic [div_w-1:0]     bit_div;
	logic [div_w-1:0]     rx_timeout;
	logic                 send_strobe;
	logic [data_bits-1:0] send_byte;
	logic                 sent;
	logic                 byte_vld;
	logic [data_bits-1:0] byte_data;
	logic                 line_idle_to;

	uart_cfg_regs u_cfg_regs (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.cfg_wr     (cfg_wr),
		.cfg_addr   (cfg_addr),
		.cfg_data   (cfg_data),
		.bit_div    (bit_div),
		.rx_timeout (rx_timeout)
	);

	// transmit path
	frame_tx u_frame_tx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.tx_req      (tx_req),
		.tx_string   (tx_string),
		.tx_length   (tx_length),
		.send_strobe (send_strobe),
		.send_byte   (send_byte),
		.sent        (sent),
		.tx_busy     (tx_busy),
		.tx_done     (tx_done)
	);

	uart_tx u_uart_tx (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.bit_div     (bit_div),
		.send_strobe (send_strobe),
		.send_byte   (send_byte),
		.txd         (uart_txd),
		.sent        (sent)
	);

	// receive path
	uart_rx u_uart_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.bit_div      (bit_div),
		.rx_timeout   (rx_timeout),
		.rxd          (uart_rxd),
		.byte_vld     (byte_vld),
		.byte_data    (byte_data),
		.line_idle_to (line_idle_to)
	);

	frame_rx u_frame_rx (
		.sys_clk      (sys_clk),
		.sys_rst_n    (sys_rst_n),
		.byte_vld     (byte_vld),
		.byte_data    (byte_data),
		.line_idle_to (line_idle_to),
		.rx_string    (rx_string),
		.rx_length    (rx_length),
		.rx_busy      (rx_busy),
		.rx_done      (rx_done)
	);

endmodule

// ==== tests/tb_clk_gen.sv ====
`timescale 1ns/100ps
// clock and reset source for the testbench
// 20 ns clock, reset held low for the first two cycles

module tb_clk_gen (
	output logic sys_clk,
	output logic sys_rst_n
);

	initial begin
		sys_clk = 1'b0;
		forever #10 sys_clk = ~sys_clk;
	end

	// released on a falling edge, away from the DUT's sampling edge
	initial begin
		sys_rst_n = 1'b0;
		repeat (2) @(negedge sys_clk);
		sys_rst_n = 1'b1;
	end

endmodule

// ==== tests/uart_string_link_chk.sv ====
`timescale 1ns/100ps
// protocol checks bound into uart_string_link
// done strobes are single pulses, the line idles high while the framer is idle

module uart_string_link_chk (
	input logic sys_clk,
	input logic sys_rst_n,
	input logic tx_busy,
	input logic tx_done,
	input logic rx_done,
	input logic uart_txd
);

	tx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> !$past(tx_done))
		else $error("tx_done high on two consecutive cycles");

	rx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> !$past(rx_done))
		else $error("rx_done high on two consecutive cycles");

	// done only ever ends a frame in flight
	tx_done_after_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> $past(tx_busy))
		else $error("tx_done without tx_busy on the cycle before");

	txd_idle_high: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_txd)
		else $error("uart_txd low while the transmit framer is idle");

endmodule

bind uart_string_link uart_string_link_chk chk (
	.sys_clk   (sys_clk),
	.sys_rst_n (sys_rst_n),
	.tx_busy   (tx_busy),
	.tx_done   (tx_done),
	.rx_done   (rx_done),
	.uart_txd  (uart_txd)
);

// ==== tests/tb_uart_string_link.sv ====
`timescale 1ns/100ps
// self-checking testbench for uart_string_link
// a table of frames runs in loopback or through a bit-banged line on uart_rxd
// line_sel picks the source, inputs change on the falling clock edge

module tb_uart_string_link;
	import uart_pkg::*;
	import frame_pkg::*;

	typedef enum int {
		mode_loop, mode_rand, mode_badlen, mode_busy, mode_bang, mode_abort, mode_ovf
	} test_mode_e;

	// bit period written to the DUT, also used by the bit-bang driver
	localparam int bit_period  = 8;
	// one 34-character frame is about 2700 cycles at this period
	localparam int frame_limit = 6000;

	logic             sys_clk;
	logic             sys_rst_n;
	logic             cfg_wr;
	cfg_addr_e        cfg_addr;
	logic [div_w-1:0] cfg_data;
	logic             tx_req;
	logic [str_w-1:0] tx_string;
	logic [len_w-1:0] tx_length;
	logic             tx_busy;
	logic             tx_done;
	logic [str_w-1:0] rx_string;
	logic [len_w-1:0] rx_length;
	logic             rx_busy;
	logic             rx_done;
	logic             uart_rxd;
	logic             uart_txd;
	logic             line_sel;
	logic             bb_rxd;

	string      t_name[$];
	string      t_payload[$];
	int         t_len[$];
	test_mode_e t_mode[$];
	string      t_exp[$];
	int         t_exp_len[$];

	integer seed;
	int     errors       = 0;
	int     test_errors  = 0;
	int     tests_failed = 0;
	int     tx_done_cnt  = 0;
	int     rx_done_cnt  = 0;
	string  cur_name;

	tb_clk_gen clk_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	// 0 loops uart_txd back, 1 hands the line to the bit-bang driver
	assign uart_rxd = line_sel ? bb_rxd : uart_txd;

	uart_string_link dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cfg_wr    (cfg_wr),
		.cfg_addr  (cfg_addr),
		.cfg_data  (cfg_data),
		.tx_req    (tx_req),
		.tx_string (tx_string),
		.tx_length (tx_length),
		.tx_busy   (tx_busy),
		.tx_done   (tx_done),
		.rx_string (rx_string),
		.rx_length (rx_length),
		.rx_busy   (rx_busy),
		.rx_done   (rx_done),
		.uart_rxd  (uart_rxd),
		.uart_txd  (uart_txd)
	);

	// done pulses counted on the rising edge, read by the main flow on the falling edge
	always @(posedge sys_clk) begin
		if (tx_done)
			tx_done_cnt <= tx_done_cnt + 1;
		if (rx_done)
			rx_done_cnt <= rx_done_cnt + 1;
	end

	task automatic add_test(input string name, input string payload, input int len,
		input test_mode_e mode, input string exp, input int exp_len);
		t_name.push_back(name);
		t_payload.push_back(payload);
		t_len.push_back(len);
		t_mode.push_back(mode);
		t_exp.push_back(exp);
		t_exp_len.push_back(exp_len);
	endtask

	task automatic load_table();
		add_test("loop_len1", "x", 1, mode_loop, "x", 1);
		add_test("loop_len5", "hello", 5, mode_loop, "hello", 5);
		add_test("loop_len32", "0123456789abcdefghijklmnopqrstuv", 32, mode_loop,
			"0123456789abcdefghijklmnopqrstuv", 32);
		add_test("rand_len1", "", 1, mode_rand, "", 1);
		add_test("rand_len5", "", 5, mode_rand, "", 5);
		add_test("rand_len32", "", 32, mode_rand, "", 32);
		add_test("len0_ignored", "abc", 0, mode_badlen, "", 0);
		add_test("len33_ignored", "abc", 33, mode_badlen, "", 0);
		add_test("req_while_busy", "first", 5, mode_busy, "first", 5);
		add_test("escaped_close", "a}b}}c", 6, mode_bang, "a}b", 3);
		add_test("idle_abort", "ab", 2, mode_abort, "", 0);
		add_test("overflow_drop", "", 33, mode_ovf, "", 0);
		add_test("loop_after_drop", "after drop", 10, mode_loop, "after drop", 10);
	endtask

	// byte 0 of the string lands in the lowest 8 bits
	function automatic logic [str_w-1:0] str_to_buf(input string s);
		logic [str_w-1:0] b;
		int               k;
		b = '0;
		for (k = 0; k < s.len() && k < max_bytes; k++)
			b[k*8 +: 8] = s[k];
		return b;
	endfunction

	function automatic logic [str_w-1:0] random_payload(input int len);
		logic [str_w-1:0] b;
		logic [7:0]       c;
		int               k;
		b = '0;
		for (k = 0; k < len; k++) begin
			c = 8'($random(seed));
			// a } here could pair up with the closing braces
			if (c == close_ch)
				c = 8'h5f;
			b[k*8 +: 8] = c;
		end
		return b;
	endfunction

	task automatic show_mismatch(input string what, input logic [str_w-1:0] exp,
		input logic [str_w-1:0] act);
		$display("[FAIL] %s %s: expected %0h, actual %0h", cur_name, what, exp, act);
		errors++;
		test_errors++;
	endtask

	task automatic note_problem(input string msg);
		$display("%s: %s", cur_name, msg);
		errors++;
		test_errors++;
	endtask

	task automatic wait_rx_done(input int start, input int limit);
		int cycles;
		cycles = 0;
		while (rx_done_cnt == start && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (rx_done_cnt == start)
			note_problem("timed out waiting for rx_done");
	endtask

	task automatic wait_tx_idle(input int limit);
		int cycles;
		cycles = 0;
		while (tx_busy && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (tx_busy)
			note_problem("timed out waiting for tx_busy to fall");
	endtask

	task automatic wait_tx_busy(input int limit);
		int cycles;
		cycles = 0;
		while (!tx_busy && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (!tx_busy)
			note_problem("tx_busy never rose after a valid request");
	endtask

	task automatic wait_rx_idle(input int limit);
		int cycles;
		cycles = 0;
		while (rx_busy && cycles < limit) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (rx_busy)
			note_problem("timed out waiting for rx_busy to fall");
	endtask

	task automatic wait_reset_release();
		int cycles;
		cycles = 0;
		while (!sys_rst_n && cycles < 20) begin
			@(negedge sys_clk);
			cycles++;
		end
		if (!sys_rst_n)
			note_problem("reset was never released");
	endtask

	task automatic write_cfg(input cfg_addr_e addr, input int value);
		@(negedge sys_clk);
		cfg_wr   = 1'b1;
		cfg_addr = addr;
		cfg_data = div_w'(value);
		@(negedge sys_clk);
		cfg_wr   = 1'b0;
	endtask

	task automatic send_request(input logic [str_w-1:0] s, input int len);
		@(negedge sys_clk);
		tx_req    = 1'b1;
		tx_string = s;
		tx_length = len_w'(len);
		@(negedge sys_clk);
		tx_req    = 1'b0;
	endtask

	// one 8N1 character on bb_rxd, lsb first
	task automatic bang_char(input logic [7:0] b);
		int k;
		bb_rxd = 1'b0;
		repeat (bit_period) @(negedge sys_clk);
		for (k = 0; k < 8; k++) begin
			bb_rxd = b[k];
			repeat (bit_period) @(negedge sys_clk);
		end
		bb_rxd = 1'b1;
		repeat (bit_period) @(negedge sys_clk);
	endtask

	task automatic bang_string(input string s);
		int k;
		for (k = 0; k < s.len(); k++)
			bang_char(s[k]);
	endtask

	task automatic run_loop(input logic [str_w-1:0] s, input int len,
		input logic [str_w-1:0] exp, input int exp_len, input bit second_req);
		int tx_start;
		int rx_start;
		tx_start = tx_done_cnt;
		rx_start = rx_done_cnt;
		line_sel = 1'b0;
		send_request(s, len);
		if (second_req) begin
			wait_tx_busy(20);
			repeat (30) @(negedge sys_clk);
			send_request(str_to_buf("SECOND"), 6);
		end
		wait_rx_done(rx_start, frame_limit);
		wait_tx_idle(frame_limit);
		repeat (4) @(negedge sys_clk);
		if (rx_string !== exp)
			show_mismatch("rx_string", exp, rx_string);
		if (rx_length !== len_w'(exp_len))
			show_mismatch("rx_length", str_w'(exp_len), str_w'(rx_length));
		if (tx_done_cnt - tx_start != 1)
			show_mismatch("tx_done pulses", 1, str_w'(tx_done_cnt - tx_start));
		if (rx_done_cnt - rx_start != 1)
			show_mismatch("rx_done pulses", 1, str_w'(rx_done_cnt - rx_start));
	endtask

	task automatic run_badlen(input string payload, input int len);
		int tx_start;
		bit seen_busy;
		int k;
		tx_start  = tx_done_cnt;
		seen_busy = 1'b0;
		send_request(str_to_buf(payload), len);
		for (k = 0; k < 50; k++) begin
			@(negedge sys_clk);
			if (tx_busy)
				seen_busy = 1'b1;
		end
		if (seen_busy)
			note_problem("tx_busy rose for a request with an invalid length");
		if (tx_done_cnt != tx_start)
			show_mismatch("tx_done pulses", 0, str_w'(tx_done_cnt - tx_start));
	endtask

	task automatic run_bang(input string payload, input logic [str_w-1:0] exp,
		input int exp_len);
		int rx_start;
		rx_start = rx_done_cnt;
		line_sel = 1'b1;
		bang_char(open_ch);
		bang_char(open_ch);
		bang_string(payload);
		wait_rx_idle(100);
		repeat (4) @(negedge sys_clk);
		line_sel = 1'b0;
		if (rx_done_cnt - rx_start != 1)
			show_mismatch("rx_done pulses", 1, str_w'(rx_done_cnt - rx_start));
		if (rx_string !== exp)
			show_mismatch("rx_string", exp, rx_string);
		if (rx_length !== len_w'(exp_len))
			show_mismatch("rx_length", str_w'(exp_len), str_w'(rx_length));
	endtask

	task automatic run_abort(input string payload);
		int               rx_start;
		logic [len_w-1:0] len_before;
		write_cfg(cfg_timeout, 200);
		len_before = rx_length;
		rx_start   = rx_done_cnt;
		line_sel   = 1'b1;
		bang_char(open_ch);
		bang_char(open_ch);
		bang_string(payload);
		if (!rx_busy)
			note_problem("receiver not busy after the opening braces");
		// idle timeout of 200 cycles plus the stop bit and margin
		wait_rx_idle(400);
		repeat (4) @(negedge sys_clk);
		line_sel = 1'b0;
		if (rx_done_cnt != rx_start)
			show_mismatch("rx_done pulses", 0, str_w'(rx_done_cnt - rx_start));
		if (rx_length !== len_before)
			show_mismatch("rx_length", str_w'(len_before), str_w'(rx_length));
	endtask

	task automatic run_overflow(input int len);
		int               rx_start;
		logic [len_w-1:0] len_before;
		int               k;
		len_before = rx_length;
		rx_start   = rx_done_cnt;
		line_sel   = 1'b1;
		bang_char(open_ch);
		bang_char(open_ch);
		for (k = 0; k < len; k++)
			bang_char(8'h7a);
		bang_char(close_ch);
		bang_char(close_ch);
		wait_rx_idle(100);
		repeat (4) @(negedge sys_clk);
		line_sel = 1'b0;
		if (rx_done_cnt != rx_start)
			show_mismatch("rx_done pulses", 0, str_w'(rx_done_cnt - rx_start));
		if (rx_length !== len_before)
			show_mismatch("rx_length", str_w'(len_before), str_w'(rx_length));
	endtask

	task automatic finish_test();
		if (test_errors == 0) begin
			$display("%-16s ok", cur_name);
		end else begin
			$display("%-16s failed with %0d errors", cur_name, test_errors);
			tests_failed++;
		end
	endtask

	task automatic run_test(input int i);
		logic [str_w-1:0] s;
		logic [str_w-1:0] e;
		cur_name    = t_name[i];
		test_errors = 0;
		e = str_to_buf(t_exp[i]);
		case (t_mode[i])
			mode_loop:   run_loop(str_to_buf(t_payload[i]), t_len[i], e, t_exp_len[i], 1'b0);
			mode_rand: begin
				s = random_payload(t_len[i]);
				run_loop(s, t_len[i], s, t_len[i], 1'b0);
			end
			mode_busy:   run_loop(str_to_buf(t_payload[i]), t_len[i], e, t_exp_len[i], 1'b1);
			mode_badlen: run_badlen(t_payload[i], t_len[i]);
			mode_bang:   run_bang(t_payload[i], e, t_exp_len[i]);
			mode_abort:  run_abort(t_payload[i]);
			default:     run_overflow(t_len[i]);
		endcase
		repeat (20) @(negedge sys_clk);
		finish_test();
	endtask

	initial begin
		int i;
		cfg_wr    = 1'b0;
		cfg_addr  = cfg_div;
		cfg_data  = '0;
		tx_req    = 1'b0;
		tx_string = '0;
		tx_length = '0;
		line_sel  = 1'b0;
		bb_rxd    = 1'b1;
		seed      = 32'hbe299270;
		load_table();
		cur_name    = "reset_values";
		test_errors = 0;
		wait_reset_release();
		@(negedge sys_clk);
		if ({tx_busy, tx_done, rx_busy, rx_done} !== 4'b0000)
			show_mismatch("status bits", 0, str_w'({tx_busy, tx_done, rx_busy, rx_done}));
		if (rx_length !== '0)
			show_mismatch("rx_length", 0, str_w'(rx_length));
		finish_test();
		write_cfg(cfg_div, bit_period);
		for (i = 0; i < t_name.size(); i++)
			run_test(i);
		$display("tests %0d, failed %0d, errors %0d", t_name.size() + 1, tests_failed, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== src.f ====
rtl/uart_pkg.sv
rtl/frame_pkg.sv
rtl/uart_cfg_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/frame_tx.sv
rtl/frame_rx.sv
rtl/uart_string_link.sv
tests/tb_clk_gen.sv
tests/uart_string_link_chk.sv
tests/tb_uart_string_link.sv

// ==== run.sh ====
#!/bin/sh
# build and run the uart_string_link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_uart_string_link -f src.f

# output goes to the terminal through stderr, the verdict is the grep status
./obj_dir/Vtb_uart_string_link 2>&1 | tee /dev/stderr | grep -q -x 'Done: no errors'
